// File: hw/legalizer_pkg.sv
// Shared constants and types of the 1D transfer legalizer
// Bus, address and length widths
// Page size used as the burst limit
// Burst descriptor struct and controller mode encoding

package legalizer_pkg;

    // ------------------------------------------------------------------
    // Bus geometry
    // ------------------------------------------------------------------
    localparam int unsigned DATA_WIDTH   = 64;
    // Bytes per beat
    localparam int unsigned STRB_WIDTH   = DATA_WIDTH / 8;
    // Byte-in-beat index bits
    localparam int unsigned OFFSET_WIDTH = $clog2(STRB_WIDTH);
    localparam int unsigned ADDR_WIDTH   = 32;
    localparam int unsigned LEN_WIDTH    = 32;

    // ------------------------------------------------------------------
    // Page rule
    // ------------------------------------------------------------------
    // 256 beats, never more than 4 KiB
    localparam int unsigned PAGE_SIZE =
        (256 * STRB_WIDTH > 4096) ? 4096 : 256 * STRB_WIDTH;
    // Byte offset within one page
    localparam int unsigned PAGE_ADDR_WIDTH = $clog2(PAGE_SIZE);

    typedef logic [ADDR_WIDTH-1:0]    addr_t;
    typedef logic [LEN_WIDTH-1:0]     len_t;
    typedef logic [OFFSET_WIDTH-1:0]  offset_t;
    // One extra bit so a full page fits
    typedef logic [PAGE_ADDR_WIDTH:0] page_len_t;
    // Beats minus one
    typedef logic [7:0]               beats_t;

    // Per-burst descriptor, 47 bits
    typedef struct packed {
        addr_t   addr;
        beats_t  len;
        offset_t offset;
        offset_t tailer;
        logic    is_single;
    } burst_t;

    // Controller state
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        COUPLED   = 2'd1,
        DECOUPLED = 2'd2
    } mode_e;

endpackage

// File: hw/side_track_if.sv
// Bundle of one side's tracker state and its step control
// Modports for the tracker, the controller and the burst former

`timescale 1ns/1ps

interface side_track_if;

    // Tracker state
    logic                      valid;
    legalizer_pkg::addr_t      addr;
    legalizer_pkg::len_t       length;
    // Bytes up to the next page boundary
    legalizer_pkg::page_len_t  to_pb;

    // Controller decisions
    // Bytes granted in this step
    legalizer_pkg::page_len_t  chunk;
    logic                      done;
    logic                      step;
    // Kill of the active transfer
    logic                      clear;

    modport tracker (
        output valid, addr, length, to_pb,
        input  chunk, done, step, clear
    );

    modport ctrl (
        input  valid, length, to_pb,
        output chunk, done, step, clear
    );

    // View used when forming the burst fields
    modport former (
        input  addr, chunk
    );

endinterface

// File: hw/transfer_tracker.sv
// Per-side transfer state of the legalizer
// Remaining length, current address and a valid bit
// Distance from the current address to the next page boundary

`timescale 1ns/1ps

module transfer_tracker (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    // New transfer from the request port
    input  logic                 load_i,
    input  legalizer_pkg::addr_t load_addr_i,
    input  legalizer_pkg::len_t  load_len_i,
    side_track_if.tracker        trk
);

    logic                 valid_q;
    legalizer_pkg::len_t  len_q;
    legalizer_pkg::addr_t addr_q;

    // Chunk widened to the address and length widths
    legalizer_pkg::addr_t chunk_addr;
    legalizer_pkg::len_t  chunk_len;

    // Byte position inside the current page
    logic [legalizer_pkg::PAGE_ADDR_WIDTH-1:0] page_off;

    assign chunk_addr = legalizer_pkg::addr_t'(trk.chunk);
    assign chunk_len  = legalizer_pkg::len_t'(trk.chunk);

    // ------------------------------------------------------------------
    // Control state
    // ------------------------------------------------------------------
    // Priority is load, then clear, then step
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
            len_q   <= '0;
        end else if (load_i) begin
            valid_q <= 1'b1;
            len_q   <= load_len_i;
        end else if (trk.clear) begin
            valid_q <= 1'b0;
            len_q   <= '0;
        end else if (trk.step) begin
            if (trk.done) begin
                // Last burst of this side taken
                valid_q <= 1'b0;
                len_q   <= '0;
            end else begin
                len_q   <= len_q - chunk_len;
            end
        end
    end

    // Current address, moves forward by each granted chunk
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            addr_q <= load_addr_i;
        end else if (trk.step && !trk.clear && !trk.done) begin
            addr_q <= addr_q + chunk_addr;
        end
    end

    // ------------------------------------------------------------------
    // Page boundary distance
    // ------------------------------------------------------------------
    assign page_off  = addr_q[legalizer_pkg::PAGE_ADDR_WIDTH-1:0];
    // Full page when sitting on a boundary
    assign trk.to_pb = legalizer_pkg::page_len_t'(legalizer_pkg::PAGE_SIZE)
                     - {1'b0, page_off};

    assign trk.valid  = valid_q;
    assign trk.addr   = addr_q;
    assign trk.length = len_q;

endmodule

// File: hw/legalizer_ctrl.sv
// Mode FSM and flow control of the legalizer
// Chunk selection for coupled and decoupled splitting
// Step enables, gated valids, request ready and kill

`timescale 1ns/1ps

module legalizer_ctrl (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       decouple_i,
    input  logic       req_valid_i,
    output logic       req_ready_o,
    input  logic       r_ready_i,
    input  logic       w_ready_i,
    input  logic       flush_i,
    input  logic       kill_i,
    output logic       r_valid_o,
    output logic       w_valid_o,
    side_track_if.ctrl rd,
    side_track_if.ctrl wr
);

    legalizer_pkg::mode_e     mode_q;
    legalizer_pkg::mode_e     mode_d;
    logic                     decoupled;
    legalizer_pkg::page_len_t c_to_pb;
    legalizer_pkg::page_len_t r_possible;
    legalizer_pkg::page_len_t w_possible;
    logic                     r_go;
    logic                     w_go;
    logic                     accept;
    logic                     r_empty_next;
    logic                     w_empty_next;

    assign decoupled = (mode_q == legalizer_pkg::DECOUPLED);

    // ------------------------------------------------------------------
    // Chunk selection
    // ------------------------------------------------------------------
    // Nearer boundary of both sides
    assign c_to_pb    = (rd.to_pb > wr.to_pb) ? wr.to_pb : rd.to_pb;
    assign r_possible = decoupled ? rd.to_pb : c_to_pb;
    assign w_possible = decoupled ? wr.to_pb : c_to_pb;

    // Capped by what is left
    assign rd.chunk = (rd.length > legalizer_pkg::len_t'(r_possible)) ?
                      r_possible : legalizer_pkg::page_len_t'(rd.length);
    assign wr.chunk = (wr.length > legalizer_pkg::len_t'(w_possible)) ?
                      w_possible : legalizer_pkg::page_len_t'(wr.length);

    // Remainder fits in this chunk, or nothing active
    assign rd.done = !rd.valid || (rd.length <= legalizer_pkg::len_t'(r_possible));
    assign wr.done = !wr.valid || (wr.length <= legalizer_pkg::len_t'(w_possible));

    // ------------------------------------------------------------------
    // Flow control
    // ------------------------------------------------------------------
    // Coupled sides wait on both readies
    assign r_go = decoupled ? r_ready_i : (r_ready_i & w_ready_i);
    assign w_go = decoupled ? w_ready_i : (r_ready_i & w_ready_i);

    assign r_valid_o = rd.valid & r_go & !flush_i;
    assign w_valid_o = wr.valid & w_go & !flush_i;

    // A presented burst is taken, so its side moves on
    assign rd.step = r_valid_o;
    assign wr.step = w_valid_o;

    assign rd.clear = kill_i;
    assign wr.clear = kill_i;

    // Kill frees both sides for the next request
    assign req_ready_o = (rd.done | kill_i) & (wr.done | kill_i)
                       & r_ready_i & w_ready_i & !flush_i;
    assign accept      = req_valid_i & req_ready_o;

    // Side empty after this edge
    assign r_empty_next = !rd.valid | (rd.step & rd.done) | kill_i;
    assign w_empty_next = !wr.valid | (wr.step & wr.done) | kill_i;

    // ------------------------------------------------------------------
    // Mode FSM
    // ------------------------------------------------------------------
    always_comb begin
        mode_d = mode_q;
        if (accept) begin
            // Decouple flag held for the whole transfer
            mode_d = decouple_i ? legalizer_pkg::DECOUPLED : legalizer_pkg::COUPLED;
        end else if (mode_q != legalizer_pkg::IDLE && r_empty_next && w_empty_next) begin
            mode_d = legalizer_pkg::IDLE;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mode_q <= legalizer_pkg::IDLE;
        end else begin
            mode_q <= mode_d;
        end
    end

endmodule

// File: hw/burst_former.sv
// Burst field arithmetic for one side
// Beat-aligned address, beat count, start and tail offsets
// Single-beat flag

`timescale 1ns/1ps

module burst_former (
    input  legalizer_pkg::addr_t     addr_i,
    input  legalizer_pkg::page_len_t bytes_i,
    output legalizer_pkg::burst_t    burst_o
);

    legalizer_pkg::offset_t   offset;
    // Span from the beat start to the end of the chunk
    legalizer_pkg::page_len_t span;
    // Index of the last byte relative to the beat start
    legalizer_pkg::page_len_t last_byte;
    legalizer_pkg::beats_t    beats;

    // Byte lane of the first byte
    assign offset = addr_i[legalizer_pkg::OFFSET_WIDTH-1:0];

    // Never beyond one page, so no overflow
    assign span      = bytes_i + legalizer_pkg::page_len_t'(offset);
    assign last_byte = span - legalizer_pkg::page_len_t'(1);

    // At most 256 beats inside a page
    assign beats = legalizer_pkg::beats_t'(last_byte >> legalizer_pkg::OFFSET_WIDTH);

    // ------------------------------------------------------------------
    // Descriptor
    // ------------------------------------------------------------------
    always_comb begin
        burst_o.addr      = {addr_i[legalizer_pkg::ADDR_WIDTH-1:legalizer_pkg::OFFSET_WIDTH],
                             {legalizer_pkg::OFFSET_WIDTH{1'b0}}};
        burst_o.len       = beats;
        burst_o.offset    = offset;
        // Zero when the chunk ends on a beat edge
        burst_o.tailer    = span[legalizer_pkg::OFFSET_WIDTH-1:0];
        burst_o.is_single = (beats == '0);
    end

endmodule

// File: hw/legalizer_top.sv
// Top level of the 1D transfer legalizer
// Flat request, read burst and write burst ports
// Two side trackers, the controller and two burst formers

`timescale 1ns/1ps

module legalizer_top (
    input  logic                  clk_i,
    input  logic                  arst_n_i,

    // 1D request
    input  legalizer_pkg::len_t   req_length_i,
    input  legalizer_pkg::addr_t  req_src_addr_i,
    input  legalizer_pkg::addr_t  req_dst_addr_i,
    input  logic                  req_decouple_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,

    // Read bursts
    output legalizer_pkg::burst_t r_burst_o,
    output logic                  r_valid_o,
    input  logic                  r_ready_i,

    // Write bursts
    output legalizer_pkg::burst_t w_burst_o,
    output logic                  w_valid_o,
    input  logic                  w_ready_i,
    output logic                  w_last_o,

    input  logic                  flush_i,
    input  logic                  kill_i,

    output logic                  r_busy_o,
    output logic                  w_busy_o
);

    logic load;

    side_track_if rd_if ();
    side_track_if wr_if ();

    // Request taken on this edge
    assign load = req_valid_i & req_ready_o;

    // ------------------------------------------------------------------
    // Side trackers
    // ------------------------------------------------------------------
    // Read side walks the source
    transfer_tracker u_rd_track (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .load_i      (load),
        .load_addr_i (req_src_addr_i),
        .load_len_i  (req_length_i),
        .trk         (rd_if.tracker)
    );

    // Write side walks the destination
    transfer_tracker u_wr_track (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .load_i      (load),
        .load_addr_i (req_dst_addr_i),
        .load_len_i  (req_length_i),
        .trk         (wr_if.tracker)
    );

    // ------------------------------------------------------------------
    // Controller
    // ------------------------------------------------------------------
    legalizer_ctrl u_ctrl (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .decouple_i  (req_decouple_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .r_ready_i   (r_ready_i),
        .w_ready_i   (w_ready_i),
        .flush_i     (flush_i),
        .kill_i      (kill_i),
        .r_valid_o   (r_valid_o),
        .w_valid_o   (w_valid_o),
        .rd          (rd_if.ctrl),
        .wr          (wr_if.ctrl)
    );

    // ------------------------------------------------------------------
    // Burst descriptors
    // ------------------------------------------------------------------
    burst_former u_rd_form (
        .addr_i  (rd_if.addr),
        .bytes_i (rd_if.chunk),
        .burst_o (r_burst_o)
    );

    burst_former u_wr_form (
        .addr_i  (wr_if.addr),
        .bytes_i (wr_if.chunk),
        .burst_o (w_burst_o)
    );

    assign r_busy_o = rd_if.valid;
    assign w_busy_o = wr_if.valid;

    // Final write burst of the transfer, low while idle
    assign w_last_o = wr_if.valid & wr_if.done;

endmodule

// File: include/legalizer_tb_checks.svh
// Reference splitting model of the legalizer testbench
// Page boundary split, coupled and decoupled
// Compare tasks for bursts, flags and counts

`ifndef LEGALIZER_TB_CHECKS_SVH
`define LEGALIZER_TB_CHECKS_SVH

// Expected bursts per side, in emission order
legalizer_pkg::burst_t r_exp[$];
legalizer_pkg::burst_t w_exp[$];

// Bytes left before the next page edge
function automatic int unsigned to_boundary(input legalizer_pkg::addr_t a);
    return legalizer_pkg::PAGE_SIZE - (a % legalizer_pkg::PAGE_SIZE);
endfunction

function automatic int unsigned smaller(input int unsigned a, input int unsigned b);
    return (a < b) ? a : b;
endfunction

// Descriptor of one chunk, straight from the field rules
function automatic legalizer_pkg::burst_t make_burst(input legalizer_pkg::addr_t a,
                                                      input int unsigned bytes);
    legalizer_pkg::burst_t b;
    int unsigned off;
    off = a % legalizer_pkg::STRB_WIDTH;
    b.addr = a - legalizer_pkg::addr_t'(off);
    b.len = legalizer_pkg::beats_t'((bytes + off - 1) / legalizer_pkg::STRB_WIDTH);
    b.offset = legalizer_pkg::offset_t'(off);
    // End lane of the last beat, zero on a full beat
    b.tailer = legalizer_pkg::offset_t'((bytes + off) % legalizer_pkg::STRB_WIDTH);
    b.is_single = (b.len == 8'd0);
    return b;
endfunction

// Burst fields as one line of text
function automatic string burst_text(input legalizer_pkg::burst_t b);
    return $sformatf("addr=%h len=%0d off=%0d tail=%0d single=%0b",
                     b.addr, b.len, b.offset, b.tailer, b.is_single);
endfunction

// ----------------------------------------------------------------------
// Split model
// ----------------------------------------------------------------------
task automatic build_expected(input legalizer_pkg::addr_t src, input legalizer_pkg::addr_t dst,
                              input legalizer_pkg::len_t len, input logic dec);
    legalizer_pkg::addr_t ra;
    legalizer_pkg::addr_t wa;
    int unsigned          r_rem;
    int unsigned          w_rem;
    int unsigned          c;
    r_exp.delete();
    w_exp.delete();
    ra = src;
    wa = dst;
    r_rem = len;
    w_rem = len;
    if (dec) begin
        // Each side on its own page grid
        while (r_rem > 0) begin
            c = smaller(to_boundary(ra), r_rem);
            r_exp.push_back(make_burst(ra, c));
            ra = ra + c;
            r_rem = r_rem - c;
        end
        while (w_rem > 0) begin
            c = smaller(to_boundary(wa), w_rem);
            w_exp.push_back(make_burst(wa, c));
            wa = wa + c;
            w_rem = w_rem - c;
        end
    end else begin
        // Both sides cut at the nearer edge
        while (r_rem > 0) begin
            c = smaller(smaller(to_boundary(ra), to_boundary(wa)), r_rem);
            r_exp.push_back(make_burst(ra, c));
            w_exp.push_back(make_burst(wa, c));
            ra = ra + c;
            wa = wa + c;
            r_rem = r_rem - c;
        end
    end
endtask

// ----------------------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------------------
task automatic check_burst(input string name, input legalizer_pkg::burst_t exp,
                           input legalizer_pkg::burst_t act);
    if (act !== exp) begin
        $display("FAIL %s: expected %s actual %s", name, burst_text(exp), burst_text(act));
        stop_run();
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("FAIL %s: expected %b actual %b", name, exp, act);
        stop_run();
    end
endtask

task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
        $display("FAIL %s: expected %0d actual %0d", name, exp, act);
        stop_run();
    end
endtask

`endif

// File: test/tb_legalizer.sv
// Testbench top of the 1D transfer legalizer
// Clock, reset, stimulus table and ready drivers
// Burst collection against the split model, watchdog

`timescale 1ns/1ps

module tb_legalizer;

    localparam int N_ROWS   = 11;
    localparam int EV_NONE  = 0;
    localparam int EV_KILL  = 1;
    localparam int EV_FLUSH = 2;

    // Ready patterns hold one bit per cycle, a set bit stalls that side
    typedef struct packed {
        legalizer_pkg::len_t  len;
        legalizer_pkg::addr_t src;
        legalizer_pkg::addr_t dst;
        logic                 dec;
        logic [15:0]          r_pat;
        logic [15:0]          w_pat;
        logic                 rnd;
        int                   ev;
        int                   ev_cyc;
        int                   ev_len;
        int                   n_rd;
        int                   n_wr;
    } row_t;

    logic                  clk;
    logic                  arst_n;
    legalizer_pkg::len_t   req_length;
    legalizer_pkg::addr_t  req_src;
    legalizer_pkg::addr_t  req_dst;
    logic                  req_decouple;
    logic                  req_valid;
    logic                  req_ready;
    legalizer_pkg::burst_t r_burst;
    logic                  r_valid;
    logic                  r_ready;
    legalizer_pkg::burst_t w_burst;
    logic                  w_valid;
    logic                  w_ready;
    logic                  w_last;
    logic                  flush;
    logic                  kill;
    logic                  r_busy;
    logic                  w_busy;

    row_t  rows [N_ROWS];
    string row_name [N_ROWS];

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    `include "legalizer_tb_checks.svh"

    legalizer_top uut (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .req_length_i   (req_length),
        .req_src_addr_i (req_src),
        .req_dst_addr_i (req_dst),
        .req_decouple_i (req_decouple),
        .req_valid_i    (req_valid),
        .req_ready_o    (req_ready),
        .r_burst_o      (r_burst),
        .r_valid_o      (r_valid),
        .r_ready_i      (r_ready),
        .w_burst_o      (w_burst),
        .w_valid_o      (w_valid),
        .w_ready_i      (w_ready),
        .w_last_o       (w_last),
        .flush_i        (flush),
        .kill_i         (kill),
        .r_busy_o       (r_busy),
        .w_busy_o       (w_busy)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic add_row(input int idx, input string name, input legalizer_pkg::len_t len,
                           input legalizer_pkg::addr_t src, input legalizer_pkg::addr_t dst,
                           input logic dec, input logic [15:0] r_pat, input logic [15:0] w_pat,
                           input logic rnd, input int ev, input int ev_cyc, input int ev_len,
                           input int n_rd, input int n_wr);
        row_name[idx] = name;
        rows[idx] = '{len, src, dst, dec, r_pat, w_pat, rnd, ev, ev_cyc, ev_len, n_rd, n_wr};
    endtask

    // ------------------------------------------------------------------
    // Stimulus table, last two columns are the burst counts per side
    // ------------------------------------------------------------------
    task automatic load_table();
        add_row(0, "short_one_beat", 32'd5, 32'h0000_1002, 32'h0000_2009, 1'b0,
                16'h0000, 16'h0000, 1'b0, EV_NONE, 0, 0, 1, 1);
        add_row(1, "short_in_page", 32'd100, 32'h0000_0103, 32'h0000_4040, 1'b1,
                16'h0000, 16'h0000, 1'b0, EV_NONE, 0, 0, 1, 1);
        add_row(2, "coupled_split", 32'd3000, 32'h0000_07F0, 32'h0001_0100, 1'b0,
                16'h0000, 16'h0000, 1'b0, EV_NONE, 0, 0, 4, 4);
        add_row(3, "decoupled_split", 32'd5000, 32'h0000_0404, 32'h0002_07FD, 1'b1,
                16'h0000, 16'h0000, 1'b0, EV_NONE, 0, 0, 3, 4);
        add_row(4, "coupled_backpressure", 32'd3000, 32'h0000_0010, 32'h0000_3A00, 1'b0,
                16'h0000, 16'h0016, 1'b0, EV_NONE, 0, 0, 3, 3);
        add_row(5, "decoupled_backpressure", 32'd3000, 32'h0000_0010, 32'h0000_3A00, 1'b1,
                16'h0000, 16'h00FF, 1'b0, EV_NONE, 0, 0, 2, 2);
        add_row(6, "coupled_random", 32'd6000, 32'h0000_1234, 32'h0000_5678, 1'b0,
                16'h0000, 16'h0000, 1'b1, EV_NONE, 0, 0, 7, 7);
        add_row(7, "decoupled_random", 32'd4100, 32'h0000_0003, 32'h0000_0FFF, 1'b1,
                16'h0000, 16'h0000, 1'b1, EV_NONE, 0, 0, 3, 4);
        add_row(8, "flush_hold", 32'd4096, 32'h0000_0000, 32'h0000_0800, 1'b0,
                16'h0000, 16'h0000, 1'b0, EV_FLUSH, 1, 4, 2, 2);
        add_row(9, "kill_mid", 32'd20000, 32'h0000_0100, 32'h0000_0000, 1'b1,
                16'h0000, 16'h0000, 1'b0, EV_KILL, 2, 1, 10, 10);
        add_row(10, "after_kill", 32'd64, 32'h0000_07F8, 32'h0000_0100, 1'b0,
                16'h0000, 16'h0000, 1'b0, EV_NONE, 0, 0, 2, 2);
    endtask

    // Readies, flush and kill for one cycle of a row
    task automatic drive_cycle(input row_t row, input int cyc);
        logic in_flush;
        in_flush = (row.ev == EV_FLUSH) && (cyc >= row.ev_cyc)
                && (cyc < row.ev_cyc + row.ev_len);
        if (row.rnd) begin
            // Roughly one stall in four
            r_ready <= ($urandom % 4) != 0;
            w_ready <= ($urandom % 4) != 0;
        end else begin
            r_ready <= !row.r_pat[4'(cyc)];
            w_ready <= !row.w_pat[4'(cyc)];
        end
        flush <= in_flush;
        kill  <= (row.ev == EV_KILL) && (cyc == row.ev_cyc);
    endtask

    // Sampled on the falling edge, a valid burst is taken at the next rise
    task automatic collect_bursts(input string nm, input logic dec);
        legalizer_pkg::burst_t exp_b;
        logic                  exp_rv;
        logic                  exp_wv;
        // Coupled sides only move when both readies are up
        exp_rv = (r_exp.size() != 0) && r_ready && (dec || w_ready) && !flush;
        exp_wv = (w_exp.size() != 0) && w_ready && (dec || r_ready) && !flush;
        check_flag({nm, " read busy"}, r_exp.size() != 0, r_busy);
        check_flag({nm, " write busy"}, w_exp.size() != 0, w_busy);
        check_flag({nm, " read valid"}, exp_rv, r_valid);
        check_flag({nm, " write valid"}, exp_wv, w_valid);
        if (flush) begin
            check_flag({nm, " request ready in flush"}, 1'b0, req_ready);
        end
        if (r_valid) begin
            exp_b = r_exp.pop_front();
            check_burst({nm, " read burst"}, exp_b, r_burst);
        end
        if (w_valid) begin
            exp_b = w_exp.pop_front();
            check_burst({nm, " write burst"}, exp_b, w_burst);
            // Last flag only on the final write burst
            check_flag({nm, " write last"}, w_exp.size() == 0, w_last);
        end
    endtask

    // ------------------------------------------------------------------
    // One table row, request through drain
    // ------------------------------------------------------------------
    task automatic run_row(input int idx);
        row_t  row;
        string nm;
        int    cyc;
        logic  killed;
        logic  finished;
        row = rows[idx];
        nm = row_name[idx];
        build_expected(row.src, row.dst, row.len, row.dec);
        check_count({nm, " model read bursts"}, row.n_rd, r_exp.size());
        check_count({nm, " model write bursts"}, row.n_wr, w_exp.size());
        @(posedge clk);
        req_length   <= row.len;
        req_src      <= row.src;
        req_dst      <= row.dst;
        req_decouple <= row.dec;
        req_valid    <= 1'b1;
        r_ready      <= 1'b1;
        w_ready      <= 1'b1;
        flush        <= 1'b0;
        kill         <= 1'b0;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        cyc = 0;
        killed = 1'b0;
        finished = 1'b0;
        while (!finished) begin
            // First pass is the accepting edge
            @(posedge clk);
            req_valid <= 1'b0;
            drive_cycle(row, cyc);
            @(negedge clk);
            if (killed) begin
                // Trackers empty one edge after kill
                check_flag({nm, " read busy after kill"}, 1'b0, r_busy);
                check_flag({nm, " write busy after kill"}, 1'b0, w_busy);
                check_flag({nm, " read valid after kill"}, 1'b0, r_valid);
                check_flag({nm, " write valid after kill"}, 1'b0, w_valid);
                finished = 1'b1;
            end else if (kill) begin
                killed = 1'b1;
            end else begin
                collect_bursts(nm, row.dec);
                finished = (r_exp.size() == 0) && (w_exp.size() == 0);
            end
            cyc++;
        end
        @(posedge clk);
        r_ready <= 1'b1;
        w_ready <= 1'b1;
        flush   <= 1'b0;
        kill    <= 1'b0;
        @(negedge clk);
        check_flag({nm, " read idle"}, 1'b0, r_busy);
        check_flag({nm, " write idle"}, 1'b0, w_busy);
        check_flag({nm, " last low when idle"}, 1'b0, w_last);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        void'($urandom(32'hefa3_0f8b));
        arst_n       = 1'b0;
        req_length   = '0;
        req_src      = '0;
        req_dst      = '0;
        req_decouple = 1'b0;
        req_valid    = 1'b0;
        r_ready      = 1'b1;
        w_ready      = 1'b1;
        flush        = 1'b0;
        kill         = 1'b0;
        load_table();
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_flag("reset read valid", 1'b0, r_valid);
        check_flag("reset write valid", 1'b0, w_valid);
        check_flag("reset read busy", 1'b0, r_busy);
        check_flag("reset write busy", 1'b0, w_busy);
        check_flag("reset write last", 1'b0, w_last);
        check_flag("reset request ready", 1'b1, req_ready);
        for (int i = 0; i < N_ROWS; i++) begin
            run_row(i);
        end
        $display("PASS: all tests");
        $finish;
    end

    // Beats of all rows plus a margin per row
    initial begin
        int unsigned limit;
        @(posedge arst_n);
        limit = 0;
        for (int i = 0; i < N_ROWS; i++) begin
            limit = limit + rows[i].len / legalizer_pkg::STRB_WIDTH + 50;
        end
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a transfer did not complete", limit);
        $display("FAIL: see errors above");
        $fatal(1);
    end

endmodule

// File: legalizer.f
+incdir+include
hw/legalizer_pkg.sv
hw/side_track_if.sv
hw/transfer_tracker.sv
hw/legalizer_ctrl.sv
hw/burst_former.sv
hw/legalizer_top.sv
test/tb_legalizer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the legalizer testbench with Verilator, run it and check the log

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=sim_legalizer

verilator --binary --timing -f legalizer.f --top-module tb_legalizer \
    -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi
echo "Simulation passed"
exit 0
